//--- Bender.yml
package:
  name: fetch_stage

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/rvc_expander.sv
      - hdl/branch_predecoder.sv
      - hdl/pc_select.sv
      - hdl/fetch_stage.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/fetch_tb.sv

//--- dv/fetch_tb.sv
// Memory model covers halfword addresses 0 to 1023 and wraps above that
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_tb;

   localparam int          MEM_HALVES = 1024;
   localparam logic [31:0] C_ADDI_EXP = 32'h0034_0413;   // addi x8, x8, 3

   logic                clk_i;
   logic                rst_i;
   logic                ctl_stall_i;
   logic                ctl_flush_i;
   logic                ctl_mispredict_o;
   logic                imem_wait_i;
   logic [`INSTR_W-1:0] imem_word_i;
   logic [`PC_W-1:0]    imem_addr_o;
   logic                exe_valid_i;
   logic                exe_taken_i;
   logic [`PC_W-1:0]    exe_target_i;
   logic [`PC_W-1:0]    exe_pc_i;
   logic                exe_compressed_i;
   logic [`PC_W-1:0]    exe_pred_next_i;
   logic [`INSTR_W-1:0] dec_instr_o;
   logic [`PC_W-1:0]    dec_pc_o;
   logic [`PC_W-1:0]    dec_pc_seq_o;
   logic [`PC_W-1:0]    dec_pred_next_o;

   logic [15:0] mem [0:MEM_HALVES-1];   // One entry per halfword
   logic [9:0]  lo_idx;
   logic [9:0]  hi_idx;
   int          seed = 14975;
   string       test_name;

   fetch_stage dut_i (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .ctl_stall_i      (ctl_stall_i),
      .ctl_flush_i      (ctl_flush_i),
      .ctl_mispredict_o (ctl_mispredict_o),
      .imem_wait_i      (imem_wait_i),
      .imem_word_i      (imem_word_i),
      .imem_addr_o      (imem_addr_o),
      .exe_valid_i      (exe_valid_i),
      .exe_taken_i      (exe_taken_i),
      .exe_target_i     (exe_target_i),
      .exe_pc_i         (exe_pc_i),
      .exe_compressed_i (exe_compressed_i),
      .exe_pred_next_i  (exe_pred_next_i),
      .dec_instr_o      (dec_instr_o),
      .dec_pc_o         (dec_pc_o),
      .dec_pc_seq_o     (dec_pc_seq_o),
      .dec_pred_next_o  (dec_pred_next_o)
   );

   // Word at any halfword including unaligned ones
   assign lo_idx      = imem_addr_o[9:0];
   assign hi_idx      = lo_idx + 10'd1;
   assign imem_word_i = {mem[hi_idx], mem[lo_idx]};

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_value(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         fail_run($sformatf("FAILED %s %s: expected %h, actual %h",
                            test_name, label, expected, actual));
      end
   endtask

   task automatic fill_memory();
      for (int i = 0; i < MEM_HALVES; i++) begin
         mem[i] = 16'($random(seed)) ^ 16'(i);   // Random filler salted with the address
      end
   endtask

   task automatic store_full(input int addr, input logic [31:0] word);
      mem[addr]     = word[15:0];   // Low parcel first
      mem[addr + 1] = word[31:16];
   endtask

   task automatic apply_reset();
      @(posedge clk_i);
      rst_i       <= 1'b1;
      ctl_stall_i <= 1'b0;
      ctl_flush_i <= 1'b0;
      imem_wait_i <= 1'b0;
      exe_valid_i <= 1'b0;
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);
   endtask

   task automatic drive_ctl(input logic stall, input logic flush, input logic mem_wait);
      @(posedge clk_i);
      ctl_stall_i <= stall;
      ctl_flush_i <= flush;
      imem_wait_i <= mem_wait;
      @(negedge clk_i);
   endtask

   task automatic report_exe(input logic taken, input logic [`PC_W-1:0] target,
                             input logic [`PC_W-1:0] pc, input logic compressed,
                             input logic [`PC_W-1:0] pred_next);
      @(posedge clk_i);
      exe_valid_i      <= 1'b1;
      exe_taken_i      <= taken;
      exe_target_i     <= target;
      exe_pc_i         <= pc;
      exe_compressed_i <= compressed;
      exe_pred_next_i  <= pred_next;
      @(negedge clk_i);
   endtask

   task automatic clear_exe();
      @(posedge clk_i);
      exe_valid_i <= 1'b0;
      @(negedge clk_i);
   endtask

   task automatic wait_addr(input int target, input int limit);
      int cycles;
      cycles = 0;
      while (imem_addr_o !== target) begin
         if (cycles == limit) begin
            fail_run($sformatf("Timeout in %s: fetch address never reached %0d",
                               test_name, target));
         end else begin
            @(posedge clk_i);
            @(negedge clk_i);
            cycles++;
         end
      end
   endtask

   task automatic check_state(input logic [31:0] instr, input int pc, input int addr);
      check_value("dec_instr_o", instr, dec_instr_o);
      check_value("dec_pc_o", pc, dec_pc_o);
      check_value("imem_addr_o", addr, imem_addr_o);
   endtask

   // After one edge the instruction fetched before it sits on the decode side
   task automatic expect_fetch(input logic [31:0] instr, input int pc, input int seq,
                               input int next);
      @(posedge clk_i);
      @(negedge clk_i);
      check_state(instr, pc, next);
      check_value("dec_pc_seq_o", seq, dec_pc_seq_o);
      check_value("dec_pred_next_o", next, dec_pred_next_o);
   endtask

   task automatic load_straight_line();
      store_full(0, 32'h0050_0093);   // addi x1, x0, 5
      mem[2] = 16'h040D;              // c.addi x8, 3
      store_full(3, 32'h0020_81B3);   // add x3, x1, x2
      mem[5] = 16'h852E;              // c.mv x10, x11
      store_full(6, 32'h0050_0093);
   endtask

   task automatic reset_state();
      test_name = "reset";
      apply_reset();
      check_value("imem_addr_o", 32'd0, imem_addr_o);
      check_value("dec_instr_o", `EBREAK_WORD, dec_instr_o);
      check_value("ctl_mispredict_o", 32'd0, ctl_mispredict_o);
   endtask

   task automatic sequential_fetch();
      test_name = "sequential";
      load_straight_line();
      apply_reset();
      expect_fetch(32'h0050_0093, 0, 2, 2);
      expect_fetch(C_ADDI_EXP, 2, 3, 3);
      expect_fetch(32'h0020_81B3, 3, 5, 5);
      expect_fetch(32'h00B0_0533, 5, 6, 6);
      expect_fetch(32'h0050_0093, 6, 8, 8);
   endtask

   task automatic compressed_expansion();
      test_name = "expansion";
      mem[0] = 16'h040D;   // c.addi x8, 3
      mem[1] = 16'h4144;   // c.lw x9, 4(x10)
      mem[2] = 16'hC504;   // c.sw x9, 8(x10)
      mem[3] = 16'h8C05;   // c.sub x8, x9
      mem[4] = 16'h852E;   // c.mv x10, x11
      mem[5] = 16'h4622;   // c.lwsp x12, 8(sp)
      mem[6] = 16'hC401;   // c.beqz x8, +8
      mem[7] = 16'hA011;   // c.j +4
      apply_reset();
      expect_fetch(C_ADDI_EXP, 0, 1, 1);
      expect_fetch(32'h0045_2483, 1, 2, 2);
      expect_fetch(32'h0095_2423, 2, 3, 3);
      expect_fetch(32'h4094_0433, 3, 4, 4);
      expect_fetch(32'h00B0_0533, 4, 5, 5);
      expect_fetch(32'h0081_2603, 5, 6, 6);
      expect_fetch(32'h0004_0463, 6, 7, 7);   // Forward so it falls through
      expect_fetch(32'h0040_006F, 7, 8, 9);   // Jumps two halfwords
   endtask

   task automatic static_prediction();
      test_name = "prediction";
      store_full(0, 32'h00C0_006F);    // jal x0, +12
      store_full(6, 32'h0020_8863);    // beq x1, x2, +16
      store_full(8, 32'h0000_8067);    // jalr x0, 0(x1)
      store_full(10, 32'hFE00_9CE3);   // bne x1, x0, -8
      apply_reset();
      expect_fetch(32'h00C0_006F, 0, 2, 6);
      expect_fetch(32'h0020_8863, 6, 8, 8);
      expect_fetch(32'h0000_8067, 8, 10, 10);
      expect_fetch(32'hFE00_9CE3, 10, 12, 6);
   endtask

   task automatic mispredict_recovery();
      test_name = "mispredict";
      load_straight_line();
      apply_reset();
      report_exe(1'b1, 40, 3, 1'b0, 5);   // Taken but predicted to fall through
      check_value("ctl_mispredict_o", 32'd1, ctl_mispredict_o);
      check_value("imem_addr_o", 32'd2, imem_addr_o);
      clear_exe();
      check_value("imem_addr_o", 32'd40, imem_addr_o);
      check_value("ctl_mispredict_o", 32'd0, ctl_mispredict_o);
      report_exe(1'b0, 0, 40, 1'b1, 41);
      check_value("ctl_mispredict_o", 32'd0, ctl_mispredict_o);
      report_exe(1'b1, 12, 6, 1'b0, 12);
      check_value("ctl_mispredict_o", 32'd0, ctl_mispredict_o);
      report_exe(1'b0, 0, 10, 1'b1, 6);   // Backward branch that was not taken
      check_value("ctl_mispredict_o", 32'd1, ctl_mispredict_o);
      clear_exe();
      check_value("imem_addr_o", 32'd11, imem_addr_o);
   endtask

   task automatic stall_flush_wait();
      test_name = "stall_flush_wait";
      for (int i = 0; i < 16; i++) begin
         mem[i] = 16'h040D;
      end
      mem[4] = 16'h852E;   // Differs so a stalled decode word must not change
      apply_reset();
      wait_addr(3, 10);
      drive_ctl(1'b1, 1'b0, 1'b0);
      check_state(C_ADDI_EXP, 3, 4);
      drive_ctl(1'b1, 1'b0, 1'b0);          // Edge sees stall
      check_state(C_ADDI_EXP, 3, 4);
      check_value("dec_pc_seq_o", 32'd4, dec_pc_seq_o);
      check_value("dec_pred_next_o", 32'd4, dec_pred_next_o);
      drive_ctl(1'b0, 1'b1, 1'b0);
      check_state(C_ADDI_EXP, 3, 4);
      drive_ctl(1'b0, 1'b0, 1'b0);          // Edge sees flush
      check_state(`EBREAK_WORD, 4, 5);
      drive_ctl(1'b0, 1'b0, 1'b1);
      check_state(C_ADDI_EXP, 5, 6);
      drive_ctl(1'b0, 1'b0, 1'b0);          // Edge sees wait
      check_state(`EBREAK_WORD, 6, 6);
      drive_ctl(1'b0, 1'b0, 1'b0);
      check_state(C_ADDI_EXP, 6, 7);
      check_value("ctl_mispredict_o", 32'd0, ctl_mispredict_o);
   endtask

   initial begin
      rst_i            <= 1'b1;
      ctl_stall_i      <= 1'b0;
      ctl_flush_i      <= 1'b0;
      imem_wait_i      <= 1'b0;
      exe_valid_i      <= 1'b0;
      exe_taken_i      <= 1'b0;
      exe_target_i     <= '0;
      exe_pc_i         <= '0;
      exe_compressed_i <= 1'b0;
      exe_pred_next_i  <= '0;
      fill_memory();
      reset_state();
      sequential_fetch();
      compressed_expansion();
      static_prediction();
      mispredict_recovery();
      stall_flush_wait();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

//--- hdl/branch_predecoder.sv
// Static prediction only and jalr targets are never predicted since they depend on a register
`timescale 1ns/1ps
`include "fetch_macros.svh"

module branch_predecoder import fetch_pkg::*; (
   input  fetch_word_t instr_i,     // Already expanded
   input  pc_t         pc_i,
   output logic        pred_taken_o,
   output pc_t         pred_target_o
);

   branch_kind_t kind;
   pc_t          b_imm;      // Halfword offsets
   logic [19:0]  j_full;     // Full jal offset in halfwords
   pc_t          imm;

   // Classify on the major opcode
   always_comb begin
      case (instr_i.rv.opcode[6:2])
         `OP_BRANCH: kind = kind_branch;
         `OP_JAL:    kind = kind_jal;
         `OP_JALR:   kind = kind_jalr;
         default:    kind = kind_other;
      endcase
   end

   // B-type offset bits 12 to 1
   assign b_imm = {{(`PC_W-12){instr_i.rv.funct7[6]}},
                   instr_i.rv.funct7[6],
                   instr_i.rv.rd[0],
                   instr_i.rv.funct7[5:0],
                   instr_i.rv.rd[4:1]};

   // J-type offset bits 20 to 1
   assign j_full = {instr_i.rv.funct7[6],
                    instr_i.rv.rs1,
                    instr_i.rv.funct3,
                    instr_i.rv.rs2[0],
                    instr_i.rv.funct7[5:0],
                    instr_i.rv.rs2[4:1]};

   // Upper jal bits fall outside the address space
   assign imm = (kind == kind_jal) ? j_full[`PC_W-1:0] : b_imm;

   assign pred_target_o = pc_i + imm;

   always_comb begin
      case (kind)
         kind_branch: pred_taken_o = b_imm[`PC_W-1];  // Backward taken, forward not
         kind_jal:    pred_taken_o = 1'b1;
         kind_jalr:   pred_taken_o = 1'b0;            // Execute fixes it
         default:     pred_taken_o = 1'b0;
      endcase
   end

endmodule

//--- hdl/fetch_macros.svh
// Fetch constants for RV32IC with PC_W counted in halfwords and kept at or below 20 bits
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Halfword address width covering byte address bits 18 to 1
`define PC_W 18

// Full instruction word
`define INSTR_W 32

// Major opcodes as seen in instruction bits 6 to 2
`define OP_BRANCH 5'b11000
`define OP_JAL    5'b11011
`define OP_JALR   5'b11001

// Quadrant bits of a full-length instruction
`define RVC_Q3 2'b11

// Fixed registers used by the compressed forms
`define REG_RA 5'd1
`define REG_SP 5'd2

// Bubble sent toward decode
// An all-zero word would decode as a load so EBREAK is used instead
`define EBREAK_WORD 32'h0010_0073

`endif

//--- hdl/fetch_pkg.sv
// Field views of a fetched word where the compressed view is valid only in the low halfword
`include "fetch_macros.svh"

package fetch_pkg;

   // Standard RV32I layout
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rv_fields_t;

   // RVC layout in the low parcel
   typedef struct packed {
      logic [15:0] upper;      // Following parcel
      logic [2:0]  funct3;
      logic [10:0] body;       // Bits 12 to 2
      logic [1:0]  quadrant;
   } rvc_fields_t;

   // Same 32 bits decoded either way
   typedef union packed {
      logic [`INSTR_W-1:0] raw;
      rv_fields_t          rv;
      rvc_fields_t         rvc;
   } fetch_word_t;

   // Halfword address
   typedef logic [`PC_W-1:0] pc_t;

   // Control transfer class seen by the static predictor
   typedef enum logic [1:0] {
      kind_other  = 2'd0,
      kind_branch = 2'd1,
      kind_jal    = 2'd2,
      kind_jalr   = 2'd3
   } branch_kind_t;

endpackage

//--- hdl/fetch_stage.sv
// Memory must return the 32-bit word at any halfword address combinationally in the same cycle
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_stage import fetch_pkg::*; (
   input  logic                clk_i,
   input  logic                rst_i,
   // Control unit
   input  logic                ctl_stall_i,
   input  logic                ctl_flush_i,
   output logic                ctl_mispredict_o,
   // Instruction memory
   input  logic                imem_wait_i,
   input  logic [`INSTR_W-1:0] imem_word_i,
   output pc_t                 imem_addr_o,
   // Execute
   input  logic                exe_valid_i,
   input  logic                exe_taken_i,
   input  pc_t                 exe_target_i,
   input  pc_t                 exe_pc_i,
   input  logic                exe_compressed_i,
   input  pc_t                 exe_pred_next_i,
   // Decode
   output logic [`INSTR_W-1:0] dec_instr_o,
   output pc_t                 dec_pc_o,
   output pc_t                 dec_pc_seq_o,
   output pc_t                 dec_pred_next_o
);

   fetch_word_t mem_word;
   fetch_word_t instr;        // After expansion
   logic        compressed;
   logic        pred_taken;
   pc_t         pred_target;
   pc_t         pc;
   pc_t         pc_seq;
   pc_t         pc_next;

   assign mem_word.raw = imem_word_i;
   assign imem_addr_o  = pc;

   rvc_expander u_expander (
      .mem_word_i   (mem_word),
      .instr_o      (instr),
      .compressed_o (compressed)
   );

   branch_predecoder u_predecoder (
      .instr_i       (instr),
      .pc_i          (pc),
      .pred_taken_o  (pred_taken),
      .pred_target_o (pred_target)
   );

   pc_select u_pc_select (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .ctl_stall_i      (ctl_stall_i),
      .imem_wait_i      (imem_wait_i),
      .compressed_i     (compressed),
      .pred_taken_i     (pred_taken),
      .pred_target_i    (pred_target),
      .exe_valid_i      (exe_valid_i),
      .exe_taken_i      (exe_taken_i),
      .exe_target_i     (exe_target_i),
      .exe_pc_i         (exe_pc_i),
      .exe_compressed_i (exe_compressed_i),
      .exe_pred_next_i  (exe_pred_next_i),
      .pc_o             (pc),
      .pc_seq_o         (pc_seq),
      .pc_next_o        (pc_next),
      .ctl_mispredict_o (ctl_mispredict_o)
   );

   // Bubble on flush or while memory has no word
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dec_instr_o <= `EBREAK_WORD;
      end else if (!ctl_stall_i) begin
         dec_instr_o <= (ctl_flush_i || imem_wait_i) ? `EBREAK_WORD : instr.raw;
      end
   end

   // Addresses travel with the instruction for the execute check
   always_ff @(posedge clk_i) begin
      if (!ctl_stall_i) begin
         dec_pc_o        <= pc;
         dec_pc_seq_o    <= pc_seq;
         dec_pred_next_o <= pc_next;
      end
   end

endmodule

//--- hdl/pc_select.sv
// Redirect from execute wins over the prediction and over a memory wait but not over a stall
`timescale 1ns/1ps

module pc_select import fetch_pkg::*; (
   input  logic clk_i,
   input  logic rst_i,
   input  logic ctl_stall_i,
   input  logic imem_wait_i,
   // Current fetch
   input  logic compressed_i,
   input  logic pred_taken_i,
   input  pc_t  pred_target_i,
   // Resolved transfer from execute
   input  logic exe_valid_i,
   input  logic exe_taken_i,
   input  pc_t  exe_target_i,
   input  pc_t  exe_pc_i,
   input  logic exe_compressed_i,
   input  pc_t  exe_pred_next_i,
   output pc_t  pc_o,
   output pc_t  pc_seq_o,
   output pc_t  pc_next_o,
   output logic ctl_mispredict_o
);

   pc_t pc_q;
   pc_t exe_next;    // Where the reported instruction really goes

   // One halfword for a compressed instruction and two for a full one
   function automatic pc_t step(input pc_t pc, input logic compressed);
      pc_t inc;
      inc = compressed ? pc_t'(1) : pc_t'(2);
      return pc + inc;
   endfunction

   assign pc_o     = pc_q;
   assign pc_seq_o = step(pc_q, compressed_i);

   // Prediction for the word at pc_q
   assign pc_next_o = pred_taken_i ? pred_target_i : pc_seq_o;

   assign exe_next = exe_taken_i ? exe_target_i : step(exe_pc_i, exe_compressed_i);

   // Combinational in the cycle execute reports
   assign ctl_mispredict_o = exe_valid_i && (exe_next != exe_pred_next_i);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pc_q <= '0;
      end else if (!ctl_stall_i) begin
         if (ctl_mispredict_o) begin
            pc_q <= exe_next;
         end else if (!imem_wait_i) begin
            pc_q <= pc_next_o;
         end
      end
   end

endmodule

//--- hdl/rvc_expander.sv
// RV32C subset only and reserved or RV64/FP compressed codes come out as EBREAK
`timescale 1ns/1ps
`include "fetch_macros.svh"

module rvc_expander import fetch_pkg::*; (
   input  fetch_word_t mem_word_i,
   output fetch_word_t instr_o,
   output logic        compressed_o
);

   logic [15:0]         c;          // Low parcel rebuilt from the RVC view
   logic [`INSTR_W-1:0] exp_word;
   logic [11:0]         imm6_sx;    // c.addi, c.li and c.andi immediate
   logic [2:0]          alu_f3;     // Funct3 for the register-register group

   assign c = {mem_word_i.rvc.funct3, mem_word_i.rvc.body, mem_word_i.rvc.quadrant};

   assign compressed_o = (mem_word_i.rvc.quadrant != `RVC_Q3);

   assign imm6_sx = {{6{c[12]}}, c[12], c[6:2]};

   // c.sub, c.xor, c.or, c.and
   always_comb begin
      case (c[6:5])
         2'b00:   alu_f3 = 3'b000;
         2'b01:   alu_f3 = 3'b100;
         2'b10:   alu_f3 = 3'b110;
         default: alu_f3 = 3'b111;
      endcase
   end

   always_comb begin
      exp_word = `EBREAK_WORD;   // Anything not matched below
      case ({c[15:13], c[1:0]})
         5'b000_00: begin // c.addi4spn
            if (c[12:5] != 8'd0) begin
               exp_word = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                           `REG_SP, 3'b000, 2'b01, c[4:2], 7'h13};
            end
         end
         5'b010_00: begin // c.lw
            exp_word = {5'd0, c[5], c[12:10], c[6], 2'b00,
                        2'b01, c[9:7], 3'b010, 2'b01, c[4:2], 7'h03};
         end
         5'b110_00: begin // c.sw
            exp_word = {5'd0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7],
                        3'b010, c[11:10], c[6], 2'b00, 7'h23};
         end
         5'b000_01: begin // c.addi and c.nop
            exp_word = {imm6_sx, c[11:7], 3'b000, c[11:7], 7'h13};
         end
         5'b001_01,
         5'b101_01: begin // c.jal links to ra and c.j to x0
            exp_word = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                        c[12], {8{c[12]}}, 4'b0000, ~c[15], 7'h6f};
         end
         5'b010_01: begin // c.li
            exp_word = {imm6_sx, 5'd0, 3'b000, c[11:7], 7'h13};
         end
         5'b011_01: begin
            if ({c[12], c[6:2]} != 6'd0) begin
               if (c[11:7] == `REG_SP) begin // c.addi16sp
                  exp_word = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000,
                              `REG_SP, 3'b000, `REG_SP, 7'h13};
               end else begin // c.lui
                  exp_word = {{15{c[12]}}, c[6:2], c[11:7], 7'h37};
               end
            end
         end
         5'b100_01: begin
            case (c[11:10])
               2'b00,
               2'b01: begin // c.srli and c.srai share the layout
                  if (!c[12]) begin
                     exp_word = {1'b0, c[10], 5'd0, c[6:2], 2'b01, c[9:7],
                                 3'b101, 2'b01, c[9:7], 7'h13};
                  end
               end
               2'b10: begin // c.andi
                  exp_word = {imm6_sx, 2'b01, c[9:7], 3'b111, 2'b01, c[9:7], 7'h13};
               end
               default: begin
                  if (!c[12]) begin // Bit 12 set is the RV64 word group
                     exp_word = {1'b0, (c[6:5] == 2'b00), 5'd0, 2'b01, c[4:2],
                                 2'b01, c[9:7], alu_f3, 2'b01, c[9:7], 7'h33};
                  end
               end
            endcase
         end
         5'b110_01,
         5'b111_01: begin // c.beqz and c.bnez
            exp_word = {c[12], {3{c[12]}}, c[6:5], c[2], 5'd0, 2'b01, c[9:7],
                        2'b00, c[13], c[11:10], c[4:3], c[12], 7'h63};
         end
         5'b000_10: begin // c.slli
            if (!c[12]) begin
               exp_word = {7'd0, c[6:2], c[11:7], 3'b001, c[11:7], 7'h13};
            end
         end
         5'b010_10: begin // c.lwsp
            if (c[11:7] != 5'd0) begin
               exp_word = {4'd0, c[3:2], c[12], c[6:4], 2'b00,
                           `REG_SP, 3'b010, c[11:7], 7'h03};
            end
         end
         5'b100_10: begin
            if (!c[12]) begin
               if (c[6:2] == 5'd0) begin
                  if (c[11:7] != 5'd0) begin // c.jr
                     exp_word = {12'd0, c[11:7], 3'b000, 5'd0, 7'h67};
                  end
               end else begin // c.mv
                  exp_word = {7'd0, c[6:2], 5'd0, 3'b000, c[11:7], 7'h33};
               end
            end else if (c[6:2] == 5'd0) begin
               if (c[11:7] != 5'd0) begin // c.jalr, otherwise c.ebreak
                  exp_word = {12'd0, c[11:7], 3'b000, `REG_RA, 7'h67};
               end
            end else begin // c.add
               exp_word = {7'd0, c[6:2], c[11:7], 3'b000, c[11:7], 7'h33};
            end
         end
         5'b110_10: begin // c.swsp
            exp_word = {4'd0, c[8:7], c[12], c[6:2], `REG_SP, 3'b010,
                        c[11:9], 2'b00, 7'h23};
         end
         default: begin
            exp_word = `EBREAK_WORD;
         end
      endcase
   end

   // Full-length words pass untouched
   assign instr_o.raw = compressed_o ? exp_word : mem_word_i.raw;

endmodule

//--- sources.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/rvc_expander.sv
hdl/branch_predecoder.sv
hdl/pc_select.sv
hdl/fetch_stage.sv
dv/fetch_tb.sv
